// File: hw/adc_pkg.sv
/* ADC types: raw and converted channel codes, four-channel frames
   and the decimation factor shared by the acquisition path */

`default_nettype none

package adc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_CH = 4;   // channels per frame
  localparam int ADC_W  = 14;  // converter code width

  ////////////////////////////////////////////////////////////////////////////
  // sample and frame types
  ////////////////////////////////////////////////////////////////////////////

  // offset binary, negative slope, straight off the pins
  typedef logic [ADC_W-1:0] adc_raw_t;

  // two's complement after conversion
  typedef logic signed [ADC_W-1:0] adc_sample_t;

  typedef struct packed {
    adc_raw_t [NUM_CH-1:0] ch;     // ch[0] in lowest bits
  } adc_raw_frame_t;

  typedef struct packed {
    adc_sample_t [NUM_CH-1:0] ch;  // same layout as raw frame
  } adc_frame_t;

  typedef logic [7:0] adc_dec_t;   // 0 and 1 keep every frame

endpackage : adc_pkg

`default_nettype wire

// File: hw/dma_pkg.sv
/* write-side types: the beat handed to the memory sink and the
   capture configuration arriving on the top-level ports */

`default_nettype none

package dma_pkg;

  localparam int ADDR_W = 32;  // byte address
  localparam int DATA_W = 64;  // one frame per beat

  typedef logic [ADDR_W-1:0] dma_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // write beat
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    dma_addr_t         addr;   // byte address of this beat
    logic [DATA_W-1:0] data;   // 16-bit lanes, ch0 in bits 15..0
    logic              last;   // final beat of a burst
  } dma_beat_t;

  ////////////////////////////////////////////////////////////////////////////
  // capture configuration
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    dma_addr_t         base_addr;   // start of circular buffer
    logic              capture_en;  // gates frames into the fifo
    adc_pkg::adc_dec_t dec;         // keep one frame in dec
  } dma_cfg_t;

endpackage : dma_pkg

`default_nettype wire

// File: hw/adc_frontend.sv
/* ADC front end: offset-binary to two's complement conversion,
   two register stages and an enable-gated decimator */

`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  logic                   adc_clk_01,
  input  logic                   reset_i,
  input  adc_pkg::adc_raw_frame_t raw_i,         // raw codes, all channels
  input  logic                   capture_en_i,
  input  adc_pkg::adc_dec_t      dec_i,         // decimation factor
  output adc_pkg::adc_frame_t    frame_o,       // to fifo write port
  output logic                   frame_vld_o    // one-cycle write strobe
);

  adc_pkg::adc_frame_t conv;      // combinational conversion
  adc_pkg::adc_frame_t conv_r;    // first register stage
  adc_pkg::adc_dec_t   cnt;       // decimation phase
  adc_pkg::adc_dec_t   cnt_eff;   // phase seen by this frame
  logic                en_d;      // enable, one cycle late
  logic                rise;      // enable rising edge
  logic                keep;      // frame passes decimator
  logic                wrap;      // phase returns to zero next
  logic                vld_r;     // valid alongside conv_r

  ////////////////////////////////////////////////////////////////////////////
  // code conversion
  ////////////////////////////////////////////////////////////////////////////

  // neg slope offset binary -> keep msb, flip the rest
  always_comb begin
    for (int i = 0; i < adc_pkg::NUM_CH; i++) begin
      conv.ch[i] = {raw_i.ch[i][adc_pkg::ADC_W-1], ~raw_i.ch[i][adc_pkg::ADC_W-2:0]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // decimation
  ////////////////////////////////////////////////////////////////////////////

  assign rise    = capture_en_i & ~en_d;
  assign cnt_eff = rise ? '0 : cnt;            // restart on enable
  assign keep    = capture_en_i & (cnt_eff == '0);
  assign wrap    = (dec_i < 8'd2) || (cnt_eff >= dec_i - 8'd1);

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      en_d        <= 1'b0;
      cnt         <= '0;
      vld_r       <= 1'b0;
      frame_vld_o <= 1'b0;
    end else begin
      en_d        <= capture_en_i;
      vld_r       <= keep;
      frame_vld_o <= vld_r;                    // valid tracks data stages
      if (capture_en_i) begin
        cnt <= wrap ? '0 : cnt_eff + 8'd1;     // holds while disabled
      end
    end
  end

  // payload pipeline, two stages
  always_ff @(posedge adc_clk_01) begin
    conv_r  <= conv;
    frame_o <= conv_r;
  end

endmodule : adc_frontend

`default_nettype wire

// File: hw/sample_fifo.sv
/* frame FIFO: circular buffer with occupancy count, drops writes
   while full and latches a sticky overflow flag */

`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter type PAYLOAD_T = logic,
  parameter int  DEPTH     = 8
)(
  input  logic     adc_clk_01,
  input  logic     reset_i,
  input  PAYLOAD_T wr_data_i,
  input  logic     wr_en_i,
  input  logic     rd_en_i,      // only while not empty
  output PAYLOAD_T rd_data_o,    // head entry
  output logic     not_empty_o,
  output logic     overflow_o    // sticky until reset
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL = CW'(DEPTH);

  PAYLOAD_T        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;       // entries held
  logic            full;
  logic            do_wr;
  logic            do_rd;

  assign full        = (count == FULL);
  assign not_empty_o = (count != '0);
  assign do_wr       = wr_en_i & ~full;         // full -> frame lost
  assign do_rd       = rd_en_i & not_empty_o;
  assign rd_data_o   = mem[rd_ptr];             // head visible at once

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;              // both or neither
      endcase
      if (wr_en_i && full) overflow_o <= 1'b1;
    end
  end

  // storage
  always_ff @(posedge adc_clk_01) begin
    if (do_wr) mem[wr_ptr] <= wr_data_i;
  end

endmodule : sample_fifo

`default_nettype wire

// File: hw/dma_writer.sv
/* frame writer: pops the FIFO, packs one frame per 64-bit beat and
   offers it with a circular-buffer address over a four-phase req/ack */

`timescale 1ns/1ps
`default_nettype none

module dma_writer #(
  parameter int BURST_LEN = 4,   // beats per burst
  parameter int BUF_WORDS = 16   // beats in circular buffer
)(
  input  logic                adc_clk_01,
  input  logic                reset_i,
  input  adc_pkg::adc_frame_t frame_i,        // fifo head
  input  logic                frame_avail_i,  // fifo not empty
  output logic                pop_o,
  input  dma_pkg::dma_addr_t  base_addr_i,
  output dma_pkg::dma_beat_t  beat_o,
  output logic                wr_req_o,
  input  logic                wr_ack_i
);

  localparam int IW     = (BUF_WORDS > 1) ? $clog2(BUF_WORDS) : 1;
  localparam int BW     = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
  localparam int LANE_W = dma_pkg::DATA_W / adc_pkg::NUM_CH;
  localparam int EXT_W  = LANE_W - adc_pkg::ADC_W;   // sign bits per lane
  localparam logic [IW-1:0] IDX_LAST   = IW'(BUF_WORDS - 1);
  localparam logic [BW-1:0] BURST_LAST = BW'(BURST_LEN - 1);

  typedef enum logic [1:0] {
    ST_IDLE,       // waiting for a frame
    ST_REQ,        // req high, beat held
    ST_WAIT_LOW    // req dropped, waiting for ack low
  } state_t;

  state_t             state;
  logic [IW-1:0]      idx;        // beat index in buffer
  logic [BW-1:0]      burst_cnt;  // position inside burst
  dma_pkg::dma_beat_t beat_d;     // next beat, built from head

  ////////////////////////////////////////////////////////////////////////////
  // beat packing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < adc_pkg::NUM_CH; i++) begin
      beat_d.data[i*LANE_W +: LANE_W] =
        {{EXT_W{frame_i.ch[i][adc_pkg::ADC_W-1]}}, frame_i.ch[i]};  // sign extend
    end
    beat_d.addr = base_addr_i + (dma_pkg::dma_addr_t'(idx) << 3);   // 8 bytes/beat
    beat_d.last = (burst_cnt == BURST_LAST);
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  assign pop_o    = (state == ST_IDLE) & frame_avail_i;
  assign wr_req_o = (state == ST_REQ);              // req one cycle after pop

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      state     <= ST_IDLE;
      idx       <= '0;
      burst_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (frame_avail_i) begin
            state     <= ST_REQ;
            idx       <= (idx == IDX_LAST) ? '0 : idx + 1'b1;          // wrap buffer
            burst_cnt <= (burst_cnt == BURST_LAST) ? '0 : burst_cnt + 1'b1;
          end
        end
        ST_REQ: begin
          if (wr_ack_i) state <= ST_WAIT_LOW;       // sink has the beat
        end
        ST_WAIT_LOW: begin
          if (!wr_ack_i) state <= ST_IDLE;          // four-phase closed
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // beat held from pop until ack seen
  always_ff @(posedge adc_clk_01) begin
    if (pop_o) beat_o <= beat_d;
  end

endmodule : dma_writer

`default_nettype wire

// File: hw/adc_capture_top.sv
/* ADC capture top: front end feeds the frame FIFO, the writer drains
   it into a circular buffer over a four-phase write handshake */

`timescale 1ns/1ps
`default_nettype none

module adc_capture_top #(
  parameter int FIFO_DEPTH = 8,
  parameter int BURST_LEN  = 4,
  parameter int BUF_WORDS  = 16
)(
  input  logic                    adc_clk_01,
  input  logic                    reset_i,
  input  adc_pkg::adc_raw_frame_t adc_raw_i,   // four raw channels
  input  dma_pkg::dma_cfg_t       cfg_i,       // static configuration
  output dma_pkg::dma_beat_t      beat_o,
  output logic                    wr_req_o,
  input  logic                    wr_ack_i,
  output logic                    overflow_o   // frame lost, sticky
);

  adc_pkg::adc_frame_t fe_frame;     // front end -> fifo
  logic                fe_vld;
  adc_pkg::adc_frame_t head_frame;   // fifo -> writer
  logic                head_avail;
  logic                pop;

  ////////////////////////////////////////////////////////////////////////////
  // producer
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend adc_frontend_inst (
    .adc_clk_01   (adc_clk_01),
    .reset_i      (reset_i),
    .raw_i        (adc_raw_i),
    .capture_en_i (cfg_i.capture_en),
    .dec_i        (cfg_i.dec),
    .frame_o      (fe_frame),
    .frame_vld_o  (fe_vld)        // no back-pressure
  );

  ////////////////////////////////////////////////////////////////////////////
  // buffer
  ////////////////////////////////////////////////////////////////////////////

  sample_fifo #(
    .PAYLOAD_T (adc_pkg::adc_frame_t),
    .DEPTH     (FIFO_DEPTH)
  ) sample_fifo_inst (
    .adc_clk_01  (adc_clk_01),
    .reset_i     (reset_i),
    .wr_data_i   (fe_frame),
    .wr_en_i     (fe_vld),
    .rd_en_i     (pop),
    .rd_data_o   (head_frame),
    .not_empty_o (head_avail),
    .overflow_o  (overflow_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // consumer
  ////////////////////////////////////////////////////////////////////////////

  dma_writer #(
    .BURST_LEN (BURST_LEN),
    .BUF_WORDS (BUF_WORDS)
  ) dma_writer_inst (
    .adc_clk_01    (adc_clk_01),
    .reset_i       (reset_i),
    .frame_i       (head_frame),
    .frame_avail_i (head_avail),
    .pop_o         (pop),
    .base_addr_i   (cfg_i.base_addr),
    .beat_o        (beat_o),
    .wr_req_o      (wr_req_o),
    .wr_ack_i      (wr_ack_i)
  );

endmodule : adc_capture_top

`default_nettype wire

// File: verif/tb_checks.svh
/* testbench helpers: LCG stimulus source and compare tasks typed to
   the capture path's frame, beat and status bits */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

`default_nettype none

int unsigned lcg_state = 32'd79239;   // fixed seed

// full-period 32-bit LCG
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic adc_pkg::adc_raw_frame_t rand_frame();
  adc_pkg::adc_raw_frame_t f;
  logic [31:0]             r;
  for (int i = 0; i < adc_pkg::NUM_CH; i++) begin
    r       = lcg_next();
    f.ch[i] = r[31:18];                  // upper bits, low ones are weak
  end
  return f;
endfunction

task automatic check_frame(input adc_pkg::adc_frame_t got, input adc_pkg::adc_frame_t exp,
                           input string what);
  if (got !== exp) begin
    $display("mismatch at %0t ns: %s frame got %h expected %h", $time, what, got, exp);
    err_cnt++;
  end
endtask

task automatic check_beat(input dma_pkg::dma_beat_t got, input dma_pkg::dma_beat_t exp,
                          input string what);
  if (got !== exp) begin
    $display("mismatch at %0t ns: %s beat addr %h/%h data %h/%h last %b/%b", $time, what,
             got.addr, exp.addr, got.data, exp.data, got.last, exp.last);
    err_cnt++;
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    err_cnt++;
  end
endtask

`default_nettype wire

`endif

// File: verif/tb_adc_capture.sv
/* testbench for the ADC capture path: directed tests for conversion,
   addressing, decimation, back-pressure, overflow and reset state */

`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture;

  localparam int FIFO_DEPTH = 8;
  localparam int BURST_LEN  = 4;
  localparam int BUF_WORDS  = 16;
  localparam int TIMEOUT    = 200;                   // cycles per wait
  localparam dma_pkg::dma_addr_t BASE = 32'h4000_0100;

  logic                    adc_clk_01;
  logic                    reset_i;
  adc_pkg::adc_raw_frame_t adc_raw_i;
  dma_pkg::dma_cfg_t       cfg_i;
  dma_pkg::dma_beat_t      beat_o;
  logic                    wr_req_o;
  logic                    wr_ack_i;
  logic                    overflow_o;

  int err_cnt  = 0;
  int test_err = 0;     // err_cnt at test start
  int n_tests  = 0;
  int n_failed = 0;
  int ack_max  = 0;     // sink delay bound, cycles
  adc_pkg::adc_raw_frame_t sent_q[$];   // presented
  adc_pkg::adc_raw_frame_t kept_q[$];   // should reach memory
  dma_pkg::dma_beat_t      got_q[$];    // taken by sink

  `include "tb_checks.svh"

  adc_capture_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .BURST_LEN  (BURST_LEN),
    .BUF_WORDS  (BUF_WORDS)
  ) adc_capture_top_inst (
    .adc_clk_01 (adc_clk_01),
    .reset_i    (reset_i),
    .adc_raw_i  (adc_raw_i),
    .cfg_i      (cfg_i),
    .beat_o     (beat_o),
    .wr_req_o   (wr_req_o),
    .wr_ack_i   (wr_ack_i),
    .overflow_o (overflow_o)
  );

  initial begin
    adc_clk_01 = 1'b0;
    forever #5 adc_clk_01 = ~adc_clk_01;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // msb kept, lower 13 bits flipped
  function automatic adc_pkg::adc_frame_t expect_frame(adc_pkg::adc_raw_frame_t raw);
    adc_pkg::adc_frame_t f;
    for (int i = 0; i < adc_pkg::NUM_CH; i++) begin
      f.ch[i] = raw.ch[i] ^ 14'h1FFF;
    end
    return f;
  endfunction

  function automatic dma_pkg::dma_beat_t expect_beat(adc_pkg::adc_raw_frame_t raw, int n);
    dma_pkg::dma_beat_t  b;
    adc_pkg::adc_frame_t f;
    f = expect_frame(raw);
    for (int i = 0; i < adc_pkg::NUM_CH; i++) begin
      b.data[16*i +: 16] = {{2{f.ch[i][13]}}, f.ch[i]};       // 16-bit lanes
    end
    b.addr = BASE + dma_pkg::dma_addr_t'(8 * (n % BUF_WORDS));  // circular
    b.last = ((n % BURST_LEN) == BURST_LEN - 1);
    return b;
  endfunction

  function automatic adc_pkg::adc_frame_t beat_frame(dma_pkg::dma_beat_t b);
    adc_pkg::adc_frame_t f;
    for (int i = 0; i < adc_pkg::NUM_CH; i++) begin
      f.ch[i] = b.data[16*i +: 14];
    end
    return f;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // drivers and sink
  ////////////////////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge adc_clk_01);
    #1;                                  // drive and sample off the edge
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (8) step();
    reset_i = 1'b0;
  endtask

  task automatic start_test();
    sent_q.delete();
    kept_q.delete();
    got_q.delete();
    ack_max          = 0;
    cfg_i.capture_en = 1'b0;
    wr_ack_i         = 1'b0;
    apply_reset();
    test_err         = err_cnt;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (err_cnt != test_err) n_failed++;
    $display("test %s: %s", name, (err_cnt == test_err) ? "ok" : "FAILED");
  endtask

  task automatic add_random(input int n);
    repeat (n) sent_q.push_back(rand_frame());
  endtask

  // one frame per cycle, enable rises with the first
  task automatic present_frames();
    foreach (sent_q[k]) begin
      adc_raw_i        = sent_q[k];
      cfg_i.capture_en = 1'b1;
      step();
    end
    cfg_i.capture_en = 1'b0;
  endtask

  // four-phase sink, quiet when running dry is expected
  task automatic serve_beats(input int n, input int window, input bit quiet);
    int t;
    for (int b = 0; b < n; b++) begin
      t = 0;
      while (!wr_req_o && t < window) begin
        step();
        t++;
      end
      if (!wr_req_o) begin
        if (!quiet) begin
          $display("timeout: no write request after %0d beats", b);
          err_cnt++;
        end
        break;
      end
      got_q.push_back(beat_o);
      repeat (int'(lcg_next() % 32'(ack_max + 1))) step();   // random ack delay
      wr_ack_i = 1'b1;
      t = 0;
      while (wr_req_o && t < TIMEOUT) begin
        step();
        t++;
      end
      if (wr_req_o) begin
        $display("timeout: write request still high long after ack");
        err_cnt++;
      end
      wr_ack_i = 1'b0;
    end
  endtask

  task automatic run_frames(input adc_pkg::adc_dec_t dec);
    int d;
    int n0;
    d  = (dec < 2) ? 1 : int'(dec);
    n0 = kept_q.size();
    foreach (sent_q[k]) begin
      if (k % d == 0) kept_q.push_back(sent_q[k]);   // phase from enable rise
    end
    cfg_i.dec = dec;
    fork
      present_frames();
      serve_beats(kept_q.size() - n0, TIMEOUT, 1'b0);
    join
    sent_q.delete();
  endtask

  // exact: count must match, else delivered must be a prefix
  task automatic compare_beats(input string name, input bit exact);
    if (exact && got_q.size() != kept_q.size()) begin
      $display("%s: %0d beats received, %0d expected", name, got_q.size(), kept_q.size());
      err_cnt++;
    end
    foreach (got_q[k]) begin
      if (k < kept_q.size()) check_beat(got_q[k], expect_beat(kept_q[k], k), name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  // frames come one per cycle and a beat takes at least three,
  // so each batch stays within one fifo's worth
  task automatic test_conversion();
    adc_pkg::adc_raw_t codes[4] = '{14'h0000, 14'h1FFF, 14'h2000, 14'h3FFF};
    start_test();
    foreach (codes[i]) sent_q.push_back({adc_pkg::NUM_CH{codes[i]}});
    add_random(FIFO_DEPTH - 4);
    run_frames(8'd1);
    add_random(FIFO_DEPTH);
    run_frames(8'd1);
    compare_beats("conversion", 1'b1);
    foreach (got_q[k]) begin
      if (k < kept_q.size())
        check_frame(beat_frame(got_q[k]), expect_frame(kept_q[k]), "conversion");
    end
    end_test("conversion");
  endtask

  task automatic test_addressing();
    start_test();
    ack_max = 2;
    repeat (3) begin                         // 24 beats, past the wrap
      add_random(FIFO_DEPTH);
      run_frames(8'd1);
    end
    compare_beats("addressing", 1'b1);
    end_test("addressing");
  endtask

  task automatic test_decimation();
    start_test();
    add_random(16);
    run_frames(8'd3);                        // phase left at 1
    add_random(7);
    run_frames(8'd3);                        // restarts at enable
    repeat (10) begin
      adc_raw_i = rand_frame();              // capture off
      step();
    end
    serve_beats(1, 50, 1'b1);                // stray beat shows as extra
    compare_beats("decimation", 1'b1);
    end_test("decimation");
  endtask

  task automatic test_backpressure();
    start_test();
    ack_max = 3;                             // beat takes at most 6 cycles
    add_random(60);
    run_frames(8'd6);
    compare_beats("backpressure", 1'b1);
    check_bit(overflow_o, 1'b0, "backpressure overflow");
    end_test("backpressure");
  endtask

  task automatic test_overflow();
    start_test();
    add_random(FIFO_DEPTH + 4);
    foreach (sent_q[k]) kept_q.push_back(sent_q[k]);
    cfg_i.dec = 8'd1;
    present_frames();                        // ack held off
    repeat (4) step();                       // front end drains
    check_bit(overflow_o, 1'b1, "overflow set");
    serve_beats(kept_q.size(), 50, 1'b1);
    compare_beats("overflow", 1'b0);
    if (got_q.size() < FIFO_DEPTH || got_q.size() >= kept_q.size()) begin
      $display("overflow: %0d of %0d frames delivered", got_q.size(), kept_q.size());
      err_cnt++;
    end
    check_bit(overflow_o, 1'b1, "overflow sticky");
    end_test("overflow");
  endtask

  task automatic test_reset();
    int t;
    start_test();
    add_random(FIFO_DEPTH + 4);
    cfg_i.dec = 8'd1;
    present_frames();                        // no ack, req stays up, fifo overflows
    t = 0;
    while (!overflow_o && t < TIMEOUT) begin
      step();
      t++;
    end
    if (!overflow_o) begin
      $display("timeout: overflow never set with ack held off");
      err_cnt++;
    end
    check_bit(wr_req_o, 1'b1, "req before reset");
    sent_q.delete();
    apply_reset();
    check_bit(wr_req_o, 1'b0, "req after reset");
    check_bit(overflow_o, 1'b0, "overflow after reset");
    add_random(1);
    run_frames(8'd1);
    compare_beats("reset", 1'b1);            // index 0 at base
    end_test("reset");
  endtask

  initial begin
    reset_i         = 1'b1;
    adc_raw_i       = '0;
    wr_ack_i        = 1'b0;
    cfg_i           = '0;
    cfg_i.base_addr = BASE;
    cfg_i.dec       = 8'd1;
    test_conversion();
    test_addressing();
    test_decimation();
    test_backpressure();
    test_overflow();
    test_reset();
    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_adc_capture

`default_nettype wire

// File: tb.f
+incdir+verif
hw/adc_pkg.sv
hw/dma_pkg.sv
hw/adc_frontend.sv
hw/sample_fifo.sv
hw/dma_writer.sv
hw/adc_capture_top.sv
verif/tb_adc_capture.sv

// File: Makefile
# Verilator build and run for the ADC capture testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/Vtb_adc_capture

obj_dir/Vtb_adc_capture: tb.f hw/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_adc_capture -Mdir obj_dir

# pass only when the log holds the pass line
run: compile
	./obj_dir/Vtb_adc_capture > sim.log 2>&1; cat sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
